/* nr1w_dup.f */
+incdir+hdl
hdl/nr1w_dup_pkg.sv
hdl/mem_req_if.sv
hdl/req_capture.sv
hdl/write_hold_buf.sv
hdl/bank_req_map.sv
hdl/read_return.sv
hdl/nr1w_dup_top.sv
sim/sram_model.sv
sim/tb_nr1w_dup.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_nr1w_dup
FILELIST  ?= nr1w_dup.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_nr1w_dup.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module tb_nr1w_dup;

  localparam int COPIES         = `NUMRDPT * `NUMVBNK;
  localparam int PADRW          = `BITVROW + `BITCOLS;
  localparam int TIMEOUT_CYCLES = 400;
  localparam int RD_LAT         = 4;  // drive edge to the sampling negedge of vread_vld.

  logic                         clk;
  logic                         rst;
  logic                         vwrite;
  logic [`BITADDR-1:0]          vwraddr;
  logic [`WIDTH-1:0]            vdin;
  logic [`NUMRDPT-1:0]          vread;
  logic [`NUMRDPT*`BITADDR-1:0] vrdaddr;
  logic [`NUMRDPT-1:0]          vread_vld;
  logic [`NUMRDPT*`WIDTH-1:0]   vdout;
  logic [`NUMRDPT-1:0]          vread_fwrd;
  logic [COPIES-1:0]            pwrite;
  logic [COPIES*PADRW-1:0]      pwrradr;
  logic [COPIES*`WIDTH-1:0]     pdin;
  logic [COPIES-1:0]            pread;
  logic [COPIES*PADRW-1:0]      prdradr;
  logic [COPIES*`WIDTH-1:0]     pdout;
  logic                         ready;

  // reference memory and per port hold buffer model.
  logic [`WIDTH-1:0]   ref_mem [1 << `BITADDR];
  logic                hv      [`NUMRDPT][`NUMCOLS];
  logic [`BITVBNK-1:0] hb      [`NUMRDPT][`NUMCOLS];
  logic [`BITVROW-1:0] hr      [`NUMRDPT][`NUMCOLS];

  // expected read returns, indexed by negedge count.
  logic                exp_vld [`NUMRDPT][512];
  logic [`WIDTH-1:0]   exp_dat [`NUMRDPT][512];
  logic                exp_fwd [`NUMRDPT][512];

  int          cyc;
  int          err_count;
  int          mon_errs;
  int          fwd_seen;
  int          tests_passed;
  int          tests_failed;
  logic        check_on;
  string       cur_test;
  logic [`BITADDR-1:0] coll_addr;

  nr1w_dup_top dut_i (
    .clk(clk), .rst(rst), .vwrite(vwrite), .vwraddr(vwraddr), .vdin(vdin),
    .vread(vread), .vrdaddr(vrdaddr), .vread_vld(vread_vld), .vdout(vdout),
    .vread_fwrd(vread_fwrd), .pwrite(pwrite), .pwrradr(pwrradr), .pdin(pdin),
    .pread(pread), .prdradr(prdradr), .pdout(pdout), .ready(ready)
  );

  sram_model sram_i (
    .clk(clk), .pwrite(pwrite), .pwrradr(pwrradr), .pdin(pdin),
    .pread(pread), .prdradr(prdradr), .pdout(pdout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##################################################
  // address split and bookkeeping
  // ##################################################
  function automatic logic [`BITVBNK-1:0] bank_of(input logic [`BITADDR-1:0] a);
    return a[`BITVBNK-1:0];
  endfunction

  function automatic logic [`BITCOLS-1:0] col_of(input logic [`BITADDR-1:0] a);
    return a[`BITVBNK +: `BITCOLS];
  endfunction

  function automatic logic [`BITVROW-1:0] row_of(input logic [`BITADDR-1:0] a);
    return a[`BITVBNK+`BITCOLS +: `BITVROW];
  endfunction

  function automatic int total_errs();
    return err_count + mon_errs;
  endfunction

  task automatic note_mismatch(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    $display("CHECK FAILED %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
    err_count = err_count + 1;
  endtask

  task automatic end_test(input int start);
    int n;
    n = total_errs() - start;
    if (n == 0) begin
      $display("%s: passed", cur_test);
      tests_passed = tests_passed + 1;
    end else begin
      $display("%s: failed with %0d errors", cur_test, n);
      tests_failed = tests_failed + 1;
    end
  endtask

  // one input cycle, plus the model's view of it.
  task automatic drive_cycle(input logic we, input logic [`BITADDR-1:0] wa,
                             input logic [`WIDTH-1:0] wd, input logic [`NUMRDPT-1:0] re,
                             input logic [`BITADDR-1:0] ra0, input logic [`BITADDR-1:0] ra1);
    logic [`BITADDR-1:0] ra [`NUMRDPT];
    logic [`BITCOLS-1:0] wc;
    logic [`BITCOLS-1:0] rc;
    logic                move;
    @(posedge clk);
    vwrite  <= we;
    vwraddr <= wa;
    vdin    <= wd;
    vread   <= re;
    vrdaddr <= {ra1, ra0};
    ra[0] = ra0;
    ra[1] = ra1;
    wc    = col_of(wa);
    for (int k = 0; k < `NUMRDPT; k++) begin
      rc = col_of(ra[k]);
      if (re[k]) begin
        exp_vld[k][cyc+RD_LAT] = 1'b1;
        exp_dat[k][cyc+RD_LAT] = ref_mem[ra[k]];  // before this cycle's write.
        exp_fwd[k][cyc+RD_LAT] = hv[k][rc] && (hb[k][rc] == bank_of(ra[k])) &&
                                 (hr[k][rc] == row_of(ra[k]));
      end
      move = we && re[k] && (bank_of(ra[k]) == bank_of(wa)) && (row_of(ra[k]) == row_of(wa));
      if (move) begin
        hv[k][wc] = 1'b1;
        hb[k][wc] = bank_of(wa);
        hr[k][wc] = row_of(wa);
      end else if (we && hv[k][wc] && (hb[k][wc] == bank_of(wa)) &&
                   (hr[k][wc] == row_of(wa))) begin
        hv[k][wc] = 1'b0;
      end
    end
    if (we) begin
      ref_mem[wa] = wd;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, '0, '0, '0);
  endtask

  // port k reads only copy bank * NUMRDPT + k.
  task automatic check_read_map(input logic [`BITADDR-1:0] ra0,
                                input logic [`BITADDR-1:0] ra1);
    logic [`BITADDR-1:0] ra [`NUMRDPT];
    logic                hit;
    logic [PADRW-1:0]    exp_padr;
    ra[0] = ra0;
    ra[1] = ra1;
    for (int c = 0; c < COPIES; c++) begin
      hit      = (c / `NUMRDPT) == int'(bank_of(ra[c % `NUMRDPT]));
      exp_padr = hit ? ra[c % `NUMRDPT][`BITADDR-1:`BITVBNK] : '0;
      if (pread[c] !== hit) note_mismatch("pread bit", 32'(hit), 32'(pread[c]));
      if (prdradr[c*PADRW +: PADRW] !== exp_padr) begin
        note_mismatch("prdradr", 32'(exp_padr), 32'(prdradr[c*PADRW +: PADRW]));
      end
    end
  endtask

  // ##################################################
  // directed tests
  // ##################################################
  task automatic test_reset();
    int start;
    cur_test = "reset";
    start    = total_errs();
    @(posedge clk);
    @(negedge clk);
    if (ready !== 1'b0) note_mismatch("ready", 32'h0, 32'(ready));
    if (pwrite !== '0) note_mismatch("pwrite", 32'h0, 32'(pwrite));
    if (pread !== '0) note_mismatch("pread", 32'h0, 32'(pread));
    @(posedge clk);
    rst <= 1'b0;  // two cycles high.
    @(negedge clk);
    if (ready !== 1'b0) note_mismatch("ready", 32'h0, 32'(ready));
    if (pwrite !== '0) note_mismatch("pwrite", 32'h0, 32'(pwrite));
    if (pread !== '0) note_mismatch("pread", 32'h0, 32'(pread));
    @(posedge clk);
    @(negedge clk);
    if (ready !== 1'b1) note_mismatch("ready", 32'h1, 32'(ready));
    if (vread_vld !== '0) note_mismatch("vread_vld", 32'h0, 32'(vread_vld));
    end_test(start);
  endtask

  task automatic test_write_map();
    int                  start;
    logic [`BITADDR-1:0] a;
    logic [`WIDTH-1:0]   d;
    logic                hit;
    cur_test = "write_map";
    start    = total_errs();
    repeat (3) begin
      a = `BITADDR'($urandom);
      d = `WIDTH'($urandom);
      drive_cycle(1'b1, a, d, '0, '0, '0);
      idle_cycles(1);
      @(negedge clk);
      for (int c = 0; c < COPIES; c++) begin
        hit = (c / `NUMRDPT) == int'(bank_of(a));  // every copy of the bank.
        if (pwrite[c] !== hit) note_mismatch("pwrite bit", 32'(hit), 32'(pwrite[c]));
        if (hit && pwrradr[c*PADRW +: PADRW] !== a[`BITADDR-1:`BITVBNK]) begin
          note_mismatch("pwrradr", 32'(a[`BITADDR-1:`BITVBNK]),
                        32'(pwrradr[c*PADRW +: PADRW]));
        end
        if (hit && pdin[c*`WIDTH +: `WIDTH] !== d) begin
          note_mismatch("pdin", d, pdin[c*`WIDTH +: `WIDTH]);
        end
      end
      if (pread !== '0) note_mismatch("pread", 32'h0, 32'(pread));
    end
    end_test(start);
  endtask

  task automatic test_read_after_write();
    int                  start;
    logic [`BITADDR-1:0] addrs [4];
    cur_test = "read_after_write";
    start    = total_errs();
    for (int i = 0; i < 4; i++) begin
      addrs[i] = `BITADDR'($urandom);
      drive_cycle(1'b1, addrs[i], `WIDTH'($urandom), '0, '0, '0);
    end
    for (int i = 0; i < 4; i++) begin
      drive_cycle(1'b0, '0, '0, 2'b11, addrs[i], addrs[(i+1)%4]);
    end
    idle_cycles(RD_LAT + 1);
    end_test(start);
  endtask

  task automatic test_parallel_reads();
    int                  start;
    logic [`BITADDR-1:0] a0;
    logic [`BITADDR-1:0] a1;
    cur_test = "parallel_reads";
    start    = total_errs();
    repeat (3) begin
      a0 = `BITADDR'($urandom);
      a1 = a0 + `BITADDR'(1 + ($urandom % 255));  // never equal to a0.
      drive_cycle(1'b1, a0, `WIDTH'($urandom), '0, '0, '0);
      drive_cycle(1'b1, a1, `WIDTH'($urandom), '0, '0, '0);
      drive_cycle(1'b0, '0, '0, 2'b11, a0, a1);
      idle_cycles(1);
      @(negedge clk);
      check_read_map(a0, a1);
    end
    idle_cycles(RD_LAT + 1);
    end_test(start);
  endtask

  task automatic test_collision_forward();
    int                  start;
    int                  fwd_start;
    logic [`BITADDR-1:0] rb;
    cur_test  = "collision_forward";
    start     = total_errs();
    fwd_start = fwd_seen;
    coll_addr = `BITADDR'($urandom);
    // same bank and row, other column.
    rb = {coll_addr[7:4], ~coll_addr[3:2], coll_addr[1:0]};
    drive_cycle(1'b1, coll_addr, `WIDTH'($urandom), 2'b01, rb, '0);
    drive_cycle(1'b0, '0, '0, 2'b11, coll_addr, coll_addr);
    idle_cycles(RD_LAT + 1);
    if (fwd_seen - fwd_start != 1) begin
      $display("%s: expected one forwarded read on port 0, saw %0d",
               cur_test, fwd_seen - fwd_start);
      err_count = err_count + 1;
    end
    end_test(start);
  endtask

  task automatic test_clear();
    int start;
    int fwd_start;
    cur_test  = "clear";
    start     = total_errs();
    fwd_start = fwd_seen;
    drive_cycle(1'b1, coll_addr, `WIDTH'($urandom), '0, '0, '0);
    drive_cycle(1'b0, '0, '0, 2'b11, coll_addr, coll_addr);
    idle_cycles(RD_LAT + 1);
    if (fwd_seen != fwd_start) begin
      $display("%s: hold entry still forwarded after a plain write", cur_test);
      err_count = err_count + 1;
    end
    end_test(start);
  endtask

  // ##################################################
  // read return monitor and timeout
  // ##################################################
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (check_on) begin
      for (int k = 0; k < `NUMRDPT; k++) begin
        if (vread_vld[k] !== exp_vld[k][cyc]) begin
          $display("CHECK FAILED %s: port %0d vread_vld expected %b actual %b",
                   cur_test, k, exp_vld[k][cyc], vread_vld[k]);
          mon_errs = mon_errs + 1;
        end else if (exp_vld[k][cyc]) begin
          if (vdout[k*`WIDTH +: `WIDTH] !== exp_dat[k][cyc]) begin
            $display("CHECK FAILED %s: port %0d vdout expected %h actual %h",
                     cur_test, k, exp_dat[k][cyc], vdout[k*`WIDTH +: `WIDTH]);
            mon_errs = mon_errs + 1;
          end
          if (vread_fwrd[k] !== exp_fwd[k][cyc]) begin
            $display("CHECK FAILED %s: port %0d vread_fwrd expected %b actual %b",
                     cur_test, k, exp_fwd[k][cyc], vread_fwrd[k]);
            mon_errs = mon_errs + 1;
          end
        end
        if (vread_fwrd[k] === 1'b1) fwd_seen = fwd_seen + 1;
      end
    end
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    void'($urandom(44743));
    rst      <= 1'b1;
    vwrite   <= 1'b0;
    vwraddr  <= '0;
    vdin     <= '0;
    vread    <= '0;
    vrdaddr  <= '0;
    check_on = 1'b0;
    for (int a = 0; a < (1 << `BITADDR); a++) ref_mem[a] = '0;
    for (int k = 0; k < `NUMRDPT; k++) begin
      for (int c = 0; c < `NUMCOLS; c++) begin
        hv[k][c] = 1'b0;
        hb[k][c] = '0;
        hr[k][c] = '0;
      end
      for (int i = 0; i < 512; i++) begin
        exp_vld[k][i] = 1'b0;
        exp_dat[k][i] = '0;
        exp_fwd[k][i] = 1'b0;
      end
    end

    test_reset();
    check_on = 1'b1;
    test_write_map();
    test_read_after_write();
    test_parallel_reads();
    test_collision_forward();
    test_clear();

    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, total_errs());
    if (total_errs() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* sim/sram_model.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module sram_model (
  input  logic                                             clk,
  input  logic [`NUMRDPT*`NUMVBNK-1:0]                     pwrite,
  input  logic [`NUMRDPT*`NUMVBNK*(`BITVROW+`BITCOLS)-1:0] pwrradr,
  input  logic [`NUMRDPT*`NUMVBNK*`WIDTH-1:0]              pdin,
  input  logic [`NUMRDPT*`NUMVBNK-1:0]                     pread,
  input  logic [`NUMRDPT*`NUMVBNK*(`BITVROW+`BITCOLS)-1:0] prdradr,
  output logic [`NUMRDPT*`NUMVBNK*`WIDTH-1:0]              pdout
);

  localparam int COPIES = `NUMRDPT * `NUMVBNK;
  localparam int DEPTH  = `NUMVROW * `NUMCOLS;
  localparam int PADRW  = `BITVROW + `BITCOLS;

  logic [`WIDTH-1:0] mem     [COPIES][DEPTH];
  logic [`WIDTH-1:0] rd_pipe [COPIES][`SRAM_DELAY];

  initial begin
    for (int c = 0; c < COPIES; c++) begin
      for (int a = 0; a < DEPTH; a++) begin
        mem[c][a] <= '0;  // all copies start cleared.
      end
    end
  end

  // ##################################################
  // one read and one write port per bank copy
  // ##################################################
  always @(posedge clk) begin
    for (int c = 0; c < COPIES; c++) begin
      // read returns old data when the write hits the same word.
      rd_pipe[c][0] <= pread[c] ? mem[c][prdradr[c*PADRW +: PADRW]] : '0;
      for (int s = 1; s < `SRAM_DELAY; s++) begin
        rd_pipe[c][s] <= rd_pipe[c][s-1];
      end
      if (pwrite[c]) begin
        mem[c][pwrradr[c*PADRW +: PADRW]] <= pdin[c*`WIDTH +: `WIDTH];
      end
    end
  end

  for (genvar c = 0; c < COPIES; c++) begin : g_out
    assign pdout[c*`WIDTH +: `WIDTH] = rd_pipe[c][`SRAM_DELAY-1];
  end

endmodule

/* hdl/nr1w_dup_top.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module nr1w_dup_top (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             vwrite,
  input  logic [`BITADDR-1:0]                              vwraddr,
  input  logic [`WIDTH-1:0]                                vdin,
  input  logic [`NUMRDPT-1:0]                              vread,
  input  logic [`NUMRDPT*`BITADDR-1:0]                     vrdaddr,
  output logic [`NUMRDPT-1:0]                              vread_vld,
  output logic [`NUMRDPT*`WIDTH-1:0]                       vdout,
  output logic [`NUMRDPT-1:0]                              vread_fwrd,
  output logic [`NUMRDPT*`NUMVBNK-1:0]                     pwrite,
  output logic [`NUMRDPT*`NUMVBNK*(`BITVROW+`BITCOLS)-1:0] pwrradr,
  output logic [`NUMRDPT*`NUMVBNK*`WIDTH-1:0]              pdin,
  output logic [`NUMRDPT*`NUMVBNK-1:0]                     pread,
  output logic [`NUMRDPT*`NUMVBNK*(`BITVROW+`BITCOLS)-1:0] prdradr,
  input  logic [`NUMRDPT*`NUMVBNK*`WIDTH-1:0]              pdout,
  output logic                                             ready
);

  mem_wr_if wr_if ();
  mem_rd_if rd_if [`NUMRDPT] ();

  logic [`NUMRDPT-1:0]        fwd_hit;
  logic [`NUMRDPT*`WIDTH-1:0] fwd_data;  // one word per port.

  req_capture capture_i (
    .clk     (clk),
    .rst     (rst),
    .vwrite  (vwrite),
    .vwraddr (vwraddr),
    .vdin    (vdin),
    .vread   (vread),
    .vrdaddr (vrdaddr),
    .ready   (ready),
    .wr      (wr_if),
    .rd      (rd_if)
  );

  bank_req_map map_i (
    .wr      (wr_if),
    .rd      (rd_if),
    .pwrite  (pwrite),
    .pwrradr (pwrradr),
    .pdin    (pdin),
    .pread   (pread),
    .prdradr (prdradr)
  );

  // ##################################################
  // per read port
  // ##################################################
  for (genvar k = 0; k < `NUMRDPT; k++) begin : g_port
    write_hold_buf hold_i (
      .clk      (clk),
      .rst      (rst),
      .wr       (wr_if),
      .rd       (rd_if[k]),
      .fwd_hit  (fwd_hit[k]),
      .fwd_data (fwd_data[k*`WIDTH +: `WIDTH])
    );

    read_return #(.PORT(k)) return_i (
      .clk        (clk),
      .rd         (rd_if[k]),
      .fwd_hit    (fwd_hit[k]),
      .fwd_data   (fwd_data[k*`WIDTH +: `WIDTH]),
      .pdout      (pdout),
      .vread_vld  (vread_vld[k]),
      .vdout      (vdout[k*`WIDTH +: `WIDTH]),
      .vread_fwrd (vread_fwrd[k])
    );
  end

endmodule

/* hdl/read_return.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module read_return #(
  parameter int PORT = 0
) (
  input  logic                                        clk,
  mem_rd_if.dst                                       rd,
  input  logic                                        fwd_hit,
  input  nr1w_dup_pkg::word_t                         fwd_data,
  input  nr1w_dup_pkg::word_t [`NUMRDPT*`NUMVBNK-1:0] pdout,
  output logic                                        vread_vld,
  output nr1w_dup_pkg::word_t                         vdout,
  output logic                                        vread_fwrd
);
  import nr1w_dup_pkg::*;

  localparam int LAST  = `SRAM_DELAY - 1;
  localparam int CSELW = $clog2(`NUMRDPT * `NUMVBNK);

  logic [`SRAM_DELAY-1:0] vld_pipe;
  logic [`SRAM_DELAY-1:0] hit_pipe;
  bank_t                  bank_pipe [`SRAM_DELAY];
  word_t                  data_pipe [`SRAM_DELAY];
  logic [CSELW-1:0]       copy_sel;

  // ##################################################
  // delay line matching the bank latency
  // ##################################################
  always_ff @(posedge clk) begin
    vld_pipe[0]  <= rd.vld;
    hit_pipe[0]  <= fwd_hit;
    bank_pipe[0] <= rd.loc.bank;
    data_pipe[0] <= fwd_data;
    for (int s = 1; s < `SRAM_DELAY; s++) begin
      vld_pipe[s]  <= vld_pipe[s-1];
      hit_pipe[s]  <= hit_pipe[s-1];
      bank_pipe[s] <= bank_pipe[s-1];
      data_pipe[s] <= data_pipe[s-1];
    end
  end

  // ##################################################
  // output select
  // ##################################################
  assign copy_sel = CSELW'(bank_pipe[LAST] * `NUMRDPT + PORT);  // own copy of the bank.

  assign vread_vld  = vld_pipe[LAST];
  assign vread_fwrd = vld_pipe[LAST] && hit_pipe[LAST];
  assign vdout      = hit_pipe[LAST] ? data_pipe[LAST] : pdout[copy_sel];

endmodule

/* hdl/bank_req_map.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module bank_req_map (
  mem_wr_if.dst                                            wr,
  mem_rd_if.dst                                            rd [`NUMRDPT],
  output logic [`NUMRDPT*`NUMVBNK-1:0]                     pwrite,
  output nr1w_dup_pkg::padr_t [`NUMRDPT*`NUMVBNK-1:0]      pwrradr,
  output nr1w_dup_pkg::word_t [`NUMRDPT*`NUMVBNK-1:0]      pdin,
  output logic [`NUMRDPT*`NUMVBNK-1:0]                     pread,
  output nr1w_dup_pkg::padr_t [`NUMRDPT*`NUMVBNK-1:0]      prdradr
);
  import nr1w_dup_pkg::*;

  padr_t wr_padr;

  assign wr_padr = {wr.loc.row, wr.loc.col};

  // ##################################################
  // copy index is bank * NUMRDPT + port
  // ##################################################
  for (genvar b = 0; b < `NUMVBNK; b++) begin : g_bank
    logic wr_hit;

    assign wr_hit = wr.vld && (wr.loc.bank == bank_t'(b));

    for (genvar k = 0; k < `NUMRDPT; k++) begin : g_copy
      logic  rd_hit;
      padr_t rd_padr;

      assign rd_hit  = rd[k].vld && (rd[k].loc.bank == bank_t'(b));
      assign rd_padr = {rd[k].loc.row, rd[k].loc.col};

      // every copy of the bank takes the write.
      assign pwrite[b*`NUMRDPT+k]  = wr_hit;
      assign pwrradr[b*`NUMRDPT+k] = wr_hit ? wr_padr : '0;
      assign pdin[b*`NUMRDPT+k]    = wr_hit ? wr.data : '0;

      // port k only reads its own copy.
      assign pread[b*`NUMRDPT+k]   = rd_hit;
      assign prdradr[b*`NUMRDPT+k] = rd_hit ? rd_padr : '0;
    end
  end

endmodule

/* hdl/write_hold_buf.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module write_hold_buf (
  input  logic                clk,
  input  logic                rst,
  mem_wr_if.dst               wr,
  mem_rd_if.dst               rd,
  output logic                fwd_hit,
  output nr1w_dup_pkg::word_t fwd_data
);
  import nr1w_dup_pkg::*;

  // one entry per column.
  logic [`NUMCOLS-1:0] hold_vld;
  bank_t               hold_bank [`NUMCOLS];
  row_t                hold_row  [`NUMCOLS];
  word_t               hold_data [`NUMCOLS];

  logic move;
  logic clear;
  logic wr_match;

  // read and write collide on the same bank row.
  assign move = rd.vld && wr.vld &&
                (rd.loc.bank == wr.loc.bank) && (rd.loc.row == wr.loc.row);

  // entry at the write column already holds this address.
  assign wr_match = hold_vld[wr.loc.col] &&
                    (hold_bank[wr.loc.col] == wr.loc.bank) &&
                    (hold_row[wr.loc.col] == wr.loc.row);

  assign clear = !move && wr.vld && wr_match;  // bank copy now has newest data.

  // ##################################################
  // entry update
  // ##################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_vld <= '0;
    end else if (move) begin
      hold_vld[wr.loc.col] <= 1'b1;
    end else if (clear) begin
      hold_vld[wr.loc.col] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (move) begin
      hold_bank[wr.loc.col] <= wr.loc.bank;
      hold_row[wr.loc.col]  <= wr.loc.row;
      hold_data[wr.loc.col] <= wr.data;
    end
  end

  // lookup sees the state before this cycle's update.
  assign fwd_hit = rd.vld && hold_vld[rd.loc.col] &&
                   (hold_bank[rd.loc.col] == rd.loc.bank) &&
                   (hold_row[rd.loc.col] == rd.loc.row);
  assign fwd_data = hold_data[rd.loc.col];

endmodule

/* hdl/req_capture.sv */
`timescale 1ns/10ps
`include "nr1w_dup_defines.svh"

module req_capture (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                vwrite,
  input  nr1w_dup_pkg::vaddr_t                vwraddr,
  input  nr1w_dup_pkg::word_t                 vdin,
  input  logic [`NUMRDPT-1:0]                 vread,
  input  nr1w_dup_pkg::vaddr_t [`NUMRDPT-1:0] vrdaddr,
  output logic                                ready,
  mem_wr_if.src                               wr,
  mem_rd_if.src                               rd [`NUMRDPT]
);
  import nr1w_dup_pkg::*;

  logic                  vwrite_q;
  vaddr_t                vwraddr_q;
  word_t                 vdin_q;
  logic [`NUMRDPT-1:0]   vread_q;
  vaddr_t [`NUMRDPT-1:0] vrdaddr_q;

  // bank in the low bits, then col, then row on top.
  function automatic loc_t split_addr(input vaddr_t addr);
    loc_t loc;
    loc.bank = addr[`BITVBNK-1:0];
    {loc.row, loc.col} = addr[`BITADDR-1:`BITVBNK];
    return loc;
  endfunction

  // ##################################################
  // strobes and ready
  // ##################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      ready    <= 1'b0;
      vwrite_q <= 1'b0;
      vread_q  <= '0;
    end else begin
      ready    <= 1'b1;                          // one cycle after reset drops.
      vwrite_q <= vwrite & ready;                // ignored until ready.
      vread_q  <= vread & {`NUMRDPT{ready}};
    end
  end

  always_ff @(posedge clk) begin
    vwraddr_q <= vwraddr;
    vdin_q    <= vdin;
    vrdaddr_q <= vrdaddr;
  end

  // ##################################################
  // drive the request interfaces
  // ##################################################
  assign wr.vld  = vwrite_q;
  assign wr.loc  = split_addr(vwraddr_q);
  assign wr.data = vdin_q;

  for (genvar i = 0; i < `NUMRDPT; i++) begin : g_rd
    assign rd[i].vld = vread_q[i];
    assign rd[i].loc = split_addr(vrdaddr_q[i]);
  end

endmodule

/* hdl/mem_req_if.sv */
`timescale 1ns/10ps

// write request after capture, shared by all bank copies.
interface mem_wr_if;
  import nr1w_dup_pkg::*;

  logic  vld;   // single cycle strobe.
  loc_t  loc;   // bank, row, col.
  word_t data;

  modport src (
    output vld,
    output loc,
    output data
  );

  modport dst (
    input vld,
    input loc,
    input data
  );
endinterface

// read request of one port after capture.
interface mem_rd_if;
  import nr1w_dup_pkg::*;

  logic vld;  // single cycle strobe.
  loc_t loc;

  modport src (
    output vld,
    output loc
  );

  modport dst (
    input vld,
    input loc
  );
endinterface

/* hdl/nr1w_dup_pkg.sv */
`include "nr1w_dup_defines.svh"

package nr1w_dup_pkg;

  // ##################################################
  // scalar fields
  // ##################################################
  typedef logic [`WIDTH-1:0]   word_t;   // one data word.
  typedef logic [`BITADDR-1:0] vaddr_t;  // virtual address.
  typedef logic [`BITVBNK-1:0] bank_t;
  typedef logic [`BITVROW-1:0] row_t;
  typedef logic [`BITCOLS-1:0] col_t;

  // ##################################################
  // composite addresses
  // ##################################################

  // split form of a virtual address.
  typedef struct packed {
    bank_t bank;
    row_t  row;
    col_t  col;
  } loc_t;

  // address inside one bank copy, column in the low bits.
  typedef struct packed {
    row_t row;
    col_t col;
  } padr_t;

endpackage

/* hdl/nr1w_dup_defines.svh */
`ifndef NR1W_DUP_DEFINES_SVH
`define NR1W_DUP_DEFINES_SVH

// ##################################################
// word and port sizes
// ##################################################
`define WIDTH      32  // data word.
`define NUMRDPT    2   // read ports, one bank copy each.

// ##################################################
// address geometry, powers of two only
// ##################################################
`define NUMVBNK    4   // banks.
`define BITVBNK    2
`define NUMVROW    16  // rows per bank.
`define BITVROW    4
`define NUMCOLS    4   // columns per row.
`define BITCOLS    2
`define BITADDR    8   // bank + row + col.

// bank read latency, pread to pdout.
`define SRAM_DELAY 2

`endif
